/* verilog/ui_pkg.sv */
// Input side types for the keypad terminal
// Key codes, ASCII characters and the 16 character message
package ui_pkg;

    localparam int MSG_CHARS = 16;          // One LCD row

    typedef logic [3:0]   key_code_t;       // row * 4 + col
    typedef logic [7:0]   char_t;           // ASCII
    typedef logic [127:0] msg_t;            // First char in top byte
    typedef logic [4:0]   msg_len_t;        // 0 to 16 chars typed

    // One-cycle key strobe from the scanner
    typedef struct packed {
        logic      valid;
        key_code_t code;
    } key_event_t;

    localparam char_t CHAR_SPACE = 8'h20;
    localparam msg_t  MSG_BLANK  = {MSG_CHARS{CHAR_SPACE}};  // Cleared message

endpackage

/* verilog/bus_pkg.sv */
// Bus side types for the keypad terminal
// APB, configuration, status and LCD bus
package bus_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic [15:0]  scan_div;     // Cycles per column
        logic [7:0]   en_width;     // LCD enable high time
        ui_pkg::msg_t row_1;        // Software text, top row
        logic         row_1_valid;  // Set once software wrote row 1
        logic [2:0]   spare;
    } cfg_t;

    typedef struct packed {
        logic [13:0]       pad;
        logic [7:0]        key_count;
        logic              busy;      // LCD refresh in progress
        ui_pkg::msg_len_t  msg_len;
        ui_pkg::key_code_t last_key;
    } status_t;

    typedef struct packed {
        logic       en;
        logic       rw;     // Write only
        logic       rs;     // 0 command, 1 data
        logic [7:0] data;
    } lcd_bus_t;

    typedef enum logic [2:0] {
        LCD_POWERUP,
        LCD_INIT,
        LCD_IDLE,
        LCD_SETUP,
        LCD_PULSE,
        LCD_HOLD,
        LCD_NEXT
    } lcd_state_e;

    // Register map
    localparam apb_addr_t ADDR_SCAN_DIV = 8'h00;
    localparam apb_addr_t ADDR_EN_WIDTH = 8'h04;
    localparam apb_addr_t ADDR_ROW_1    = 8'h08;  // Four words up to 0x14
    localparam apb_addr_t ADDR_STATUS   = 8'h18;

    localparam logic [15:0] SCAN_DIV_RST = 16'd16;
    localparam logic [7:0]  EN_WIDTH_RST = 8'd4;

endpackage

/* verilog/keypad_scan.sv */
// 4x4 keypad scanner
// Drives one column low at a time, debounces whole scans, emits one event per press
module keypad_scan #(
    parameter int DEBOUNCE_SCANS = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [15:0]        scan_div,
    input  logic [3:0]         readrow,   // Active low
    output logic [3:0]         scancol,   // Active low, one cold
    output ui_pkg::key_event_t key
);

    localparam int CW = $clog2(DEBOUNCE_SCANS + 1);

    logic [15:0]       div_cnt;
    logic [1:0]        col_idx;
    logic              col_last;      // Last cycle of this column
    logic [1:0]        col_nxt;
    logic [15:0]       cur_bits;      // Pressed bits of the scan in progress
    logic [15:0]       cur_next;
    logic              cand_hit;
    ui_pkg::key_code_t cand_code;
    logic              prev_hit;
    ui_pkg::key_code_t prev_code;
    logic [CW-1:0]     stable_cnt;
    logic [CW-1:0]     cnt_nxt;
    logic              held_hit;      // Debounced pressed state

    // 17 bits so scan_div of 0 acts as 1
    assign col_last = ({1'b0, div_cnt} + 17'd1) >= {1'b0, scan_div};
    assign col_nxt  = col_last ? col_idx + 2'd1 : col_idx;

    // Merge this column's rows into the running scan
    always_comb begin
        cur_next = cur_bits;
        for (int r = 0; r < 4; r++) begin
            cur_next[r * 4 + int'(col_idx)] = !readrow[r];
        end
    end

    // Lowest code wins when several keys are down
    always_comb begin
        cand_hit  = 1'b0;
        cand_code = '0;
        for (int i = 15; i >= 0; i--) begin
            if (cur_next[i]) begin
                cand_hit  = 1'b1;
                cand_code = ui_pkg::key_code_t'(i);
            end
        end
    end

    always_comb begin
        if (cand_hit != prev_hit || cand_code != prev_code) begin
            cnt_nxt = CW'(1);             // Changed, restart count
        end else if (stable_cnt < CW'(DEBOUNCE_SCANS)) begin
            cnt_nxt = stable_cnt + CW'(1);
        end else begin
            cnt_nxt = stable_cnt;         // Saturate
        end
    end

    always_ff @(posedge clk) begin
        if (col_last) begin
            cur_bits <= cur_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt    <= '0;
            col_idx    <= '0;
            scancol    <= '1;             // No column driven
            prev_hit   <= 1'b0;
            prev_code  <= '0;
            stable_cnt <= '0;
            held_hit   <= 1'b0;
            key        <= '0;
        end else begin
            div_cnt   <= col_last ? '0 : div_cnt + 16'd1;
            col_idx   <= col_nxt;
            scancol   <= ~(4'b0001 << col_nxt);
            key.valid <= 1'b0;
            if (col_last && col_idx == 2'd3) begin   // Full scan done
                prev_hit   <= cand_hit;
                prev_code  <= cand_code;
                stable_cnt <= cnt_nxt;
                if (cnt_nxt == CW'(DEBOUNCE_SCANS)) begin
                    held_hit <= cand_hit;
                    if (cand_hit && !held_hit) begin  // Press edge only
                        key.valid <= 1'b1;
                        key.code  <= cand_code;
                    end
                end
            end
        end
    end

endmodule

/* verilog/msg_assembler.sv */
// Message builder
// Maps keys to ASCII, fills the 16 char buffer, clears on '*' and commits on '#'
module msg_assembler (
    input  logic               clk,
    input  logic               rst,
    input  ui_pkg::key_event_t key,
    output ui_pkg::msg_t       msg,
    output ui_pkg::msg_len_t   msg_len,
    output logic               commit,     // One cycle, msg still valid
    output ui_pkg::key_code_t  last_key,
    output logic [7:0]         key_count
);

    ui_pkg::char_t ch;

    // Keypad legend, row by row
    function automatic ui_pkg::char_t key_to_char(input ui_pkg::key_code_t code);
        case (code)
            4'd0:    return "1";
            4'd1:    return "2";
            4'd2:    return "3";
            4'd3:    return "A";
            4'd4:    return "4";
            4'd5:    return "5";
            4'd6:    return "6";
            4'd7:    return "B";
            4'd8:    return "7";
            4'd9:    return "8";
            4'd10:   return "9";
            4'd11:   return "C";
            4'd12:   return "*";
            4'd13:   return "0";
            4'd14:   return "#";
            default: return "D";
        endcase
    endfunction

    assign ch = key_to_char(key.code);

    always_ff @(posedge clk) begin
        if (rst) begin
            msg       <= ui_pkg::MSG_BLANK;
            msg_len   <= '0;
            commit    <= 1'b0;
            last_key  <= '0;
            key_count <= '0;
        end else begin
            commit <= 1'b0;
            if (commit) begin               // Driver has latched it
                msg     <= ui_pkg::MSG_BLANK;
                msg_len <= '0;
            end
            if (key.valid) begin
                last_key <= key.code;
                if (key_count != 8'hFF) begin
                    key_count <= key_count + 8'd1;
                end
                case (ch)
                    "*": begin
                        msg     <= ui_pkg::MSG_BLANK;
                        msg_len <= '0;
                    end
                    "#": commit <= 1'b1;
                    default: begin
                        // Extra chars past 16 dropped
                        if (msg_len < 5'(ui_pkg::MSG_CHARS)) begin
                            msg[8 * (ui_pkg::MSG_CHARS - 1 - int'(msg_len)) +: 8] <= ch;
                            msg_len <= msg_len + 5'd1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

/* verilog/lcd1602_driver.sv */
// HD44780 1602 write-only driver
// Power-up init, then a full two-row refresh per commit with fixed enable timing
module lcd1602_driver #(
    parameter int POWERUP_WAIT = 200
) (
    input  logic              clk,
    input  logic              rst,
    input  ui_pkg::msg_t      row_1,
    input  ui_pkg::msg_t      msg,
    input  logic              commit,
    input  logic [7:0]        en_width,
    output bus_pkg::lcd_bus_t lcd,
    output logic              busy
);

    localparam int PW        = $clog2(POWERUP_WAIT + 1);
    localparam int LAST_INIT = 3;    // 0x38 0x0C 0x06 0x01
    localparam int ROW_2_CMD = 17;   // 0xC0 slot
    localparam int LAST_BYTE = 33;   // 0x80, 16 chars, 0xC0, 16 chars

    bus_pkg::lcd_state_e state;
    logic [PW-1:0]       pwr_cnt;
    logic [7:0]          pulse_cnt;
    logic [5:0]          idx;         // Byte within init or refresh
    logic                in_init;
    logic                pending;     // One-deep commit queue
    ui_pkg::msg_t        pend_msg;
    ui_pkg::msg_t        row1_q;
    ui_pkg::msg_t        row2_q;
    ui_pkg::char_t       byte_data;
    logic                byte_rs;

    assign busy = (state != bus_pkg::LCD_IDLE) || pending;

    // Byte for the current index
    always_comb begin
        byte_rs   = 1'b0;
        byte_data = 8'h00;
        if (in_init) begin
            case (idx[1:0])
                2'd0:    byte_data = 8'h38;   // 8-bit, 2 lines
                2'd1:    byte_data = 8'h0C;   // Display on, no cursor
                2'd2:    byte_data = 8'h06;   // Entry mode increment
                default: byte_data = 8'h01;   // Clear
            endcase
        end else if (idx == 6'd0) begin
            byte_data = 8'h80;                // DDRAM row 1
        end else if (idx == 6'(ROW_2_CMD)) begin
            byte_data = 8'hC0;                // DDRAM row 2
        end else if (idx < 6'(ROW_2_CMD)) begin
            byte_rs   = 1'b1;
            byte_data = row1_q[8 * (16 - int'(idx)) +: 8];
        end else begin
            byte_rs   = 1'b1;
            byte_data = row2_q[8 * (LAST_BYTE - int'(idx)) +: 8];
        end
    end

    // Bus is quiet outside a byte transfer
    always_comb begin
        lcd = '0;
        if (state inside {bus_pkg::LCD_SETUP, bus_pkg::LCD_PULSE, bus_pkg::LCD_HOLD}) begin
            lcd.rs   = byte_rs;
            lcd.data = byte_data;
            lcd.en   = (state == bus_pkg::LCD_PULSE);
        end
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            pend_msg <= msg;
        end
        if (state == bus_pkg::LCD_IDLE && pending) begin   // Refresh start
            row1_q <= row_1;
            row2_q <= pend_msg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= bus_pkg::LCD_POWERUP;
            pwr_cnt   <= '0;
            pulse_cnt <= '0;
            idx       <= '0;
            in_init   <= 1'b0;
            pending   <= 1'b0;
        end else begin
            case (state)
                bus_pkg::LCD_POWERUP: begin
                    pwr_cnt <= pwr_cnt + PW'(1);
                    if (pwr_cnt == PW'(POWERUP_WAIT - 1)) state <= bus_pkg::LCD_INIT;
                end
                bus_pkg::LCD_INIT: begin
                    in_init <= 1'b1;
                    idx     <= '0;
                    state   <= bus_pkg::LCD_SETUP;
                end
                bus_pkg::LCD_IDLE: begin
                    if (pending) begin
                        pending <= 1'b0;
                        idx     <= '0;
                        state   <= bus_pkg::LCD_SETUP;
                    end
                end
                bus_pkg::LCD_SETUP: begin
                    pulse_cnt <= 8'd1;
                    state     <= bus_pkg::LCD_PULSE;
                end
                bus_pkg::LCD_PULSE: begin
                    pulse_cnt <= pulse_cnt + 8'd1;
                    if (pulse_cnt >= en_width) state <= bus_pkg::LCD_HOLD;  // 0 acts as 1
                end
                bus_pkg::LCD_HOLD: state <= bus_pkg::LCD_NEXT;
                default: begin                                // LCD_NEXT
                    if (idx == 6'(in_init ? LAST_INIT : LAST_BYTE)) begin
                        in_init <= 1'b0;
                        state   <= bus_pkg::LCD_IDLE;
                    end else begin
                        idx   <= idx + 6'd1;
                        state <= bus_pkg::LCD_SETUP;
                    end
                end
            endcase
            if (commit) pending <= 1'b1;   // Newest commit wins
        end
    end

endmodule

/* verilog/apb_cfg_regs.sv */
// APB register block
// Scan rate, LCD enable width, row 1 text and a live status word
module apb_cfg_regs (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::apb_req_t req,
    input  bus_pkg::status_t  status,
    output bus_pkg::apb_rsp_t rsp,
    output bus_pkg::cfg_t     cfg
);

    logic               access;      // Access phase of a transfer
    logic               row_hit;
    logic [1:0]         row_word;    // 0 holds the first four chars
    logic               hit;
    bus_pkg::apb_data_t rdata;

    assign access   = req.psel && req.penable;
    assign row_hit  = req.paddr >= bus_pkg::ADDR_ROW_1 && req.paddr < bus_pkg::ADDR_STATUS
                      && req.paddr[1:0] == 2'b00;
    assign row_word = 2'(req.paddr[4:2] - 3'd2);

    // Address decode and read mux
    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        if (req.paddr == bus_pkg::ADDR_SCAN_DIV) begin
            rdata = {16'h0, cfg.scan_div};
        end else if (req.paddr == bus_pkg::ADDR_EN_WIDTH) begin
            rdata = {24'h0, cfg.en_width};
        end else if (row_hit) begin
            rdata = cfg.row_1[32 * (3 - int'(row_word)) +: 32];
        end else if (req.paddr == bus_pkg::ADDR_STATUS) begin
            rdata = status;                  // Live, read only
        end else begin
            hit = 1'b0;
        end
    end

    always_comb begin
        rsp.pready  = 1'b1;                  // No wait states
        rsp.pslverr = access && !hit && !rst;  // Quiet while held in reset
        rsp.prdata  = (access && hit) ? rdata : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.scan_div    <= bus_pkg::SCAN_DIV_RST;
            cfg.en_width    <= bus_pkg::EN_WIDTH_RST;
            cfg.row_1       <= ui_pkg::MSG_BLANK;
            cfg.row_1_valid <= 1'b0;
            cfg.spare       <= '0;
        end else if (access && req.pwrite && hit) begin
            if (req.paddr == bus_pkg::ADDR_SCAN_DIV) cfg.scan_div <= req.pwdata[15:0];
            if (req.paddr == bus_pkg::ADDR_EN_WIDTH) cfg.en_width <= req.pwdata[7:0];
            if (row_hit) begin
                cfg.row_1[32 * (3 - int'(row_word)) +: 32] <= req.pwdata;
                cfg.row_1_valid <= 1'b1;
            end
        end
    end

endmodule

/* verilog/ssdec.sv */
// Seven-segment hex decoder, segments gfedcba, blank when disabled
module ssdec (
    input  ui_pkg::key_code_t in,
    input  logic              enable,
    output logic [6:0]        seg
);

    always_comb begin
        if (!enable) begin
            seg = 7'b0000000;
        end else begin
            case (in)
                4'h0:    seg = 7'b0111111;
                4'h1:    seg = 7'b0000110;
                4'h2:    seg = 7'b1011011;
                4'h3:    seg = 7'b1001111;
                4'h4:    seg = 7'b1100110;
                4'h5:    seg = 7'b1101101;
                4'h6:    seg = 7'b1111101;
                4'h7:    seg = 7'b0000111;
                4'h8:    seg = 7'b1111111;
                4'h9:    seg = 7'b1100111;
                4'hA:    seg = 7'b1110111;
                4'hB:    seg = 7'b1111100;   // Lower case b
                4'hC:    seg = 7'b0111001;
                4'hD:    seg = 7'b1011110;   // Lower case d
                4'hE:    seg = 7'b1111001;
                default: seg = 7'b1110001;
            endcase
        end
    end

endmodule

/* verilog/keypad_lcd_top.sv */
// Keypad to LCD message terminal
// Scanner, message builder, LCD driver, APB registers and key display
module keypad_lcd_top #(
    parameter int DEBOUNCE_SCANS = 3,
    parameter int POWERUP_WAIT   = 200
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              en,        // Chip enable, low holds all in reset
    input  bus_pkg::apb_req_t apb_req,
    input  logic [3:0]        readrow,
    output bus_pkg::apb_rsp_t apb_rsp,
    output logic [3:0]        scancol,
    output bus_pkg::lcd_bus_t lcd,
    output logic              msg_tx,
    output logic [6:0]        seg
);

    logic               blk_rst;
    ui_pkg::key_event_t key;
    ui_pkg::msg_t       msg;
    ui_pkg::msg_len_t   msg_len;
    logic               commit;
    ui_pkg::key_code_t  last_key;
    logic [7:0]         key_count;
    logic               lcd_busy;
    bus_pkg::cfg_t      cfg;
    bus_pkg::status_t   status;

    assign blk_rst = rst || !en;
    assign msg_tx  = commit;
    assign status  = '{pad: '0, key_count: key_count, busy: lcd_busy,
                       msg_len: msg_len, last_key: last_key};

    keypad_scan #(.DEBOUNCE_SCANS(DEBOUNCE_SCANS)) u_scan (
        .clk(clk), .rst(blk_rst), .scan_div(cfg.scan_div), .readrow(readrow),
        .scancol(scancol), .key(key)
    );

    msg_assembler u_msg (
        .clk(clk), .rst(blk_rst), .key(key), .msg(msg), .msg_len(msg_len),
        .commit(commit), .last_key(last_key), .key_count(key_count)
    );

    lcd1602_driver #(.POWERUP_WAIT(POWERUP_WAIT)) u_lcd (
        .clk(clk), .rst(blk_rst), .row_1(cfg.row_1), .msg(msg), .commit(commit),
        .en_width(cfg.en_width), .lcd(lcd), .busy(lcd_busy)
    );

    apb_cfg_regs u_regs (
        .clk(clk), .rst(blk_rst), .req(apb_req), .status(status),
        .rsp(apb_rsp), .cfg(cfg)
    );

    // Display stays dark until the first key
    ssdec u_seg (
        .in(last_key), .enable(key_count != 8'd0), .seg(seg)
    );

endmodule

/* bench/keypad_lcd_properties.sv */
// Protocol checks for the keypad LCD terminal
// LCD bus timing, column scan shape and commit strobe width
module keypad_lcd_properties (
    input logic              clk,
    input logic              rst,
    input logic              en,
    input bus_pkg::lcd_bus_t lcd,
    input logic [3:0]        scancol,
    input logic              msg_tx
);
    timeunit 1ns;
    timeprecision 100ps;

    logic blk_rst;

    assign blk_rst = rst || !en;   // Same reset the blocks see

    // Write-only port
    rw_low: assert property (@(posedge clk) lcd.rw == 1'b0)
        else $error("lcd.rw went high");

    // Bus held while the enable pulse is up
    data_stable: assert property (@(posedge clk) disable iff (blk_rst)
        lcd.en |=> (!lcd.en || ($stable(lcd.data) && $stable(lcd.rs))))
        else $error("lcd data or rs moved during the enable pulse");

    // First cycle out of reset still shows the idle columns
    one_cold: assert property (@(posedge clk) disable iff (blk_rst)
        !$past(blk_rst) |-> $countones(~scancol) == 1)
        else $error("scancol does not have exactly one low column");

    tx_single: assert property (@(posedge clk) msg_tx |=> !msg_tx)
        else $error("msg_tx high for two cycles");

endmodule

bind keypad_lcd_top keypad_lcd_properties u_props (
    .clk(clk), .rst(rst), .en(en), .lcd(lcd), .scancol(scancol), .msg_tx(msg_tx)
);

/* bench/keypad_lcd_tb.sv */
// Testbench for the keypad LCD terminal
// Keypad model, LCD monitor, APB tasks and a stimulus file reader
module keypad_lcd_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    DEBOUNCE_SCANS = 3;
    localparam int    POWERUP_WAIT   = 200;
    localparam string STIM_FILE      = "bench/keypad_lcd_stim.txt";

    logic              clk;
    logic              rst;
    logic              en;
    bus_pkg::apb_req_t apb_req;
    bus_pkg::apb_rsp_t apb_rsp;
    logic [3:0]        readrow;
    logic [3:0]        scancol;
    bus_pkg::lcd_bus_t lcd;
    logic              msg_tx;
    logic [6:0]        seg;

    logic              key_down;          // Keypad model state
    ui_pkg::key_code_t key_held;
    logic [15:0]       lfsr_state;
    logic [8:0]        lcd_q[$];          // {rs, data} per enable pulse
    logic [8:0]        exp_q[$];
    string             lines[$];
    int                tx_count;
    int                cur_div;           // Last scan_div written
    longint            watch_ns;

    keypad_lcd_top #(.DEBOUNCE_SCANS(DEBOUNCE_SCANS), .POWERUP_WAIT(POWERUP_WAIT)) dut (
        .clk(clk), .rst(rst), .en(en), .apb_req(apb_req), .readrow(readrow),
        .apb_rsp(apb_rsp), .scancol(scancol), .lcd(lcd), .msg_tx(msg_tx), .seg(seg)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Held key pulls its row low while its column is driven
    function automatic logic [3:0] key_rows(input logic down, input ui_pkg::key_code_t code,
                                            input logic [3:0] cols);
        logic [3:0] rows;
        rows = 4'hF;
        if (down && !cols[code[1:0]]) rows[code[3:2]] = 1'b0;
        return rows;
    endfunction

    always @(posedge clk) readrow <= key_rows(key_down, key_held, scancol);

    always @(negedge lcd.en) lcd_q.push_back({lcd.rs, lcd.data});  // LCD latches here

    always @(negedge clk) if (msg_tx) tx_count = tx_count + 1;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);   // One step per bit
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input bus_pkg::apb_data_t exp,
                              input bus_pkg::apb_data_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_char(input string name, input ui_pkg::char_t exp,
                              input ui_pkg::char_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_seg(input string name, input logic [6:0] exp, input logic [6:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_error($sformatf("Error: %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_with_error($sformatf("Error: %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // Setup cycle, then one access cycle since pready is tied high
    task automatic apb_xfer(input string name, input logic wr,
                            input bus_pkg::apb_addr_t addr,
                            input bus_pkg::apb_data_t wdata,
                            output bus_pkg::apb_data_t rdata, output logic err);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);                       // Mid access cycle
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_bit({name, " pready"}, 1'b1, apb_rsp.pready);
        @(posedge clk);
        apb_req <= '0;
    endtask

    // Hold and gap both well past the debounce window
    task automatic press_key(input ui_pkg::key_code_t code);
        int scan_cycles;
        int hold;
        int gap;
        scan_cycles = 4 * cur_div;
        hold = (DEBOUNCE_SCANS + 3 + random_bits(3)) * scan_cycles;
        gap  = (DEBOUNCE_SCANS + 3 + random_bits(3)) * scan_cycles;
        @(posedge clk);
        key_held <= code;
        key_down <= 1'b1;
        repeat (hold) @(posedge clk);
        key_down <= 1'b0;
        repeat (gap) @(posedge clk);
    endtask

    task automatic wait_idle(input string name);
        bus_pkg::apb_data_t rd;
        bus_pkg::status_t   st;
        logic               err;
        do begin
            apb_xfer({name, " status poll"}, 1'b0, bus_pkg::ADDR_STATUS, '0, rd, err);
            st = bus_pkg::status_t'(rd);
        end while (st.busy);
    endtask

    // Compares everything the LCD latched since the last check
    task automatic check_lcd_bytes(input string name);
        logic [8:0] got;
        wait_idle(name);
        check_count({name, " byte count"}, exp_q.size(), lcd_q.size());
        foreach (exp_q[i]) begin
            got = lcd_q[i];
            check_bit($sformatf("%s rs %0d", name, i), exp_q[i][8], got[8]);
            check_char($sformatf("%s data %0d", name, i), exp_q[i][7:0], got[7:0]);
        end
        lcd_q.delete();
        exp_q.delete();
    endtask

    task automatic check_frame(input string name, input ui_pkg::msg_t row_1,
                               input ui_pkg::msg_t row_2);
        exp_q.push_back({1'b0, 8'h80});       // Row 1 address
        for (int i = 0; i < 16; i++) exp_q.push_back({1'b1, row_1[8 * (15 - i) +: 8]});
        exp_q.push_back({1'b0, 8'hC0});       // Row 2 address
        for (int i = 0; i < 16; i++) exp_q.push_back({1'b1, row_2[8 * (15 - i) +: 8]});
        check_lcd_bytes(name);
    endtask

    task automatic load_stim();
        int    fd;
        string line;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) stop_with_error({"cannot open the stimulus file ", STIM_FILE});
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.substr(0, 1) != "//") lines.push_back(line);
        end
        $fclose(fd);
    endtask

    // Every operation gets the worst of one key press or one refresh
    task automatic set_watchdog();
        string        name;
        string        op;
        logic [127:0] a;
        logic [127:0] b;
        longint       ops;
        longint       max_div;
        longint       max_width;
        longint       key_cyc;
        longint       lcd_cyc;
        ops       = 0;
        max_div   = longint'(bus_pkg::SCAN_DIV_RST);
        max_width = longint'(bus_pkg::EN_WIDTH_RST);
        foreach (lines[i]) begin
            void'($sscanf(lines[i], "%s %s %h %h", name, op, a, b));
            ops += (op == "K") ? longint'(b[15:0]) : 1;
            if (op == "W" && a[7:0] == 8'h00 && longint'(b[15:0]) > max_div) begin
                max_div = longint'(b[15:0]);
            end
            if (op == "W" && a[7:0] == 8'h04 && longint'(b[7:0]) > max_width) begin
                max_width = longint'(b[7:0]);
            end
        end
        key_cyc  = 2 * (DEBOUNCE_SCANS + 3 + 7) * 4 * max_div;
        lcd_cyc  = 38 * (max_width + 3) + POWERUP_WAIT + 60;
        watch_ns = 2 * ops * ((key_cyc > lcd_cyc ? key_cyc : lcd_cyc) + 8) * 40;
    endtask

    initial begin
        wait (watch_ns != 0);
        #(watch_ns);
        stop_with_error($sformatf("timeout: the run did not finish within %0d ns", watch_ns));
    end

    task automatic run_line(input string line);
        string              name;
        string              op;
        logic [127:0]       a;
        logic [127:0]       b;
        bus_pkg::apb_data_t rd;
        logic               err;
        a = '0;
        b = '0;
        void'($sscanf(line, "%s %s %h %h", name, op, a, b));
        case (op)
            "W": begin
                apb_xfer(name, 1'b1, bus_pkg::apb_addr_t'(a), bus_pkg::apb_data_t'(b), rd, err);
                check_bit({name, " pslverr"}, 1'b0, err);   // Read-only writes too
                if (a[7:0] == bus_pkg::ADDR_SCAN_DIV) cur_div = int'(b[15:0]);
            end
            "R": begin
                apb_xfer(name, 1'b0, bus_pkg::apb_addr_t'(a), '0, rd, err);
                check_bit({name, " pslverr"}, 1'b0, err);
                check_word(name, bus_pkg::apb_data_t'(b), rd);
            end
            "E": begin
                apb_xfer(name, 1'b0, bus_pkg::apb_addr_t'(a), '0, rd, err);
                check_bit({name, " pslverr"}, 1'b1, err);
                check_word({name, " prdata"}, '0, rd);
            end
            "K": repeat (int'(b[15:0])) press_key(ui_pkg::key_code_t'(a));
            "S": begin
                @(negedge clk);
                check_seg(name, a[6:0], seg);
            end
            "I": begin
                exp_q = '{9'h038, 9'h00C, 9'h006, 9'h001};  // Function set to clear
                check_lcd_bytes(name);
            end
            "F": check_frame(name, a, b);
            "M": check_count(name, int'(a[15:0]), tx_count);
            default: stop_with_error({"unknown stimulus operation in line: ", line});
        endcase
    endtask

    initial begin
        rst        = 1'b1;
        en         = 1'b0;
        apb_req    = '0;
        readrow    = '1;
        key_down   = 1'b0;
        key_held   = '0;
        lfsr_state = 16'd29;
        tx_count   = 0;
        cur_div    = int'(bus_pkg::SCAN_DIV_RST);
        watch_ns   = 0;
        load_stim();
        set_watchdog();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        en  <= 1'b1;
        foreach (lines[i]) run_line(lines[i]);
        repeat (4) @(posedge clk);
        $display("test passed");
        $finish;
    end

endmodule

/* filelist.f */
verilog/ui_pkg.sv
verilog/bus_pkg.sv
verilog/keypad_scan.sv
verilog/msg_assembler.sv
verilog/lcd1602_driver.sv
verilog/apb_cfg_regs.sv
verilog/ssdec.sv
verilog/keypad_lcd_top.sv
bench/keypad_lcd_properties.sv
bench/keypad_lcd_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the keypad LCD testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module keypad_lcd_tb \
    -f filelist.f \
    -Mdir obj_dir -o keypad_lcd_sim

./obj_dir/keypad_lcd_sim

/* bench/keypad_lcd_stim.txt */
// name op a b, all numbers hex. W/R addr data, E addr (expect pslverr), K code count,
// S seg, I (init bytes), F row1 row2 (128-bit text), M msg_tx pulse count
init I
rst_scan R 00 00000010
rst_width R 04 00000004
rst_row_a R 08 20202020
rst_row_d R 14 20202020
rst_status R 18 00000000
seg_blank S 00
key_1 K 0 1
key_2 K 1 1
key_a K 3 1
status_mid R 18 00000C33
seg_a S 4F
key_send K E 1
frame_1 F 20202020202020202020202020202020 31324120202020202020202020202020
tx_1 M 1
status_sent R 18 0000100E
seg_e S 79
row_w0 W 08 48454C4C
row_w1 W 0C 4F20574F
row_w2 W 10 524C4420
row_w3 W 14 31323334
row_rd1 R 0C 4F20574F
key_4 K 4 1
key_5 K 5 1
key_star K C 1
key_7 K 8 1
key_send2 K E 1
frame_2 F 48454C4C4F20574F524C442031323334 37202020202020202020202020202020
key_8_x17 K 9 11
key_send3 K E 1
frame_3 F 48454C4C4F20574F524C442031323334 38383838383838383838383838383838
tx_3 M 3
status_count R 18 00006C0E
bad_addr E 1C
bad_align E 09
status_ro W 18 FFFFFFFF
status_kept R 18 00006C0E
scan_fast W 00 00000008
en_wide W 04 00000009
scan_rd R 00 00000008
width_rd R 04 00000009
key_9 K A 1
key_d K F 1
key_0 K D 1
key_send4 K E 1
frame_4 F 48454C4C4F20574F524C442031323334 39443020202020202020202020202020
tx_4 M 4
seg_last S 79
